//--- verilog/isa_pkg.sv
package isa_pkg;

    localparam int XLEN    = 32;
    localparam int SHAMT_W = 5;    // Shift amount bits taken from opb

    // ALU and multiply functions share one encoding space
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_MUL,
        ALU_MULH,
        ALU_MULHSU,
        ALU_MULHU
    } alu_func_e;

    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_e;

    typedef enum logic [1:0] {
        BK_COND,    // Conditional branch
        BK_JAL,     // Direct jump
        BK_JALR     // Register indirect jump
    } br_kind_e;

endpackage

//--- verilog/exec_pkg.sv
package exec_pkg;

    import isa_pkg::*;

    // Reorder buffer tag carried through every unit
    localparam int TAG_W = 6;

    // Multiplier pipeline depth, 2, 4 or 8
    localparam int MULT_STAGES = 4;

    // Cycles from mult_en to mult_done
    localparam int MULT_LATENCY = MULT_STAGES + 1;

    // Full product width
    localparam int PROD_W = 2 * XLEN;

    // Multiplier bits consumed per stage
    localparam int SLICE_W = PROD_W / MULT_STAGES;

    // Return address step for jumps
    localparam logic [XLEN-1:0] LINK_OFS = 4;

endpackage

//--- verilog/alu.sv
`timescale 1ns/100ps

module alu import isa_pkg::*, exec_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  logic [XLEN-1:0]  opa,
    input  logic [XLEN-1:0]  opb,
    input  alu_func_e        func,
    input  logic             alu_en,
    input  logic [TAG_W-1:0] in_tag,
    output logic [XLEN-1:0]  result,
    output logic             alu_done,
    output logic [TAG_W-1:0] out_tag
);

    logic [XLEN-1:0]        opa_r;
    logic [XLEN-1:0]        opb_r;
    logic signed [XLEN-1:0] sopa;
    logic signed [XLEN-1:0] sopb;
    logic [SHAMT_W-1:0]     shamt;
    alu_func_e              func_r;

    assign sopa  = opa_r;
    assign sopb  = opb_r;
    assign shamt = opb_r[SHAMT_W-1:0];    // Upper bits ignored

    always_comb begin
        case (func_r)
            ALU_ADD:  result = opa_r + opb_r;
            ALU_SUB:  result = opa_r - opb_r;
            ALU_AND:  result = opa_r & opb_r;
            ALU_OR:   result = opa_r | opb_r;
            ALU_XOR:  result = opa_r ^ opb_r;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, sopa < sopb};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, opa_r < opb_r};
            ALU_SLL:  result = opa_r << shamt;
            ALU_SRL:  result = opa_r >> shamt;
            ALU_SRA:  result = sopa >>> shamt;    // Sign fills from the left
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            alu_done <= 1'b0;
            opa_r    <= '0;
            opb_r    <= '0;
            func_r   <= ALU_ADD;
            out_tag  <= '0;
        end else begin
            alu_done <= alu_en;
            if (alu_en) begin
                opa_r   <= opa;
                opb_r   <= opb;
                func_r  <= func;
                out_tag <= in_tag;
            end
        end
    end

endmodule

//--- verilog/branch_unit.sv
`timescale 1ns/100ps

module branch_unit import isa_pkg::*, exec_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  logic [XLEN-1:0]  pc,
    input  logic [XLEN-1:0]  rs1,
    input  logic [XLEN-1:0]  rs2,
    input  logic [XLEN-1:0]  imm,
    input  br_kind_e         kind,
    input  br_cond_e         cond,
    input  logic             branch_en,
    input  logic [TAG_W-1:0] in_tag,
    output logic             take,
    output logic [XLEN-1:0]  target,
    output logic [XLEN-1:0]  link,
    output logic             branch_done,
    output logic [TAG_W-1:0] out_tag
);

    logic [XLEN-1:0]        pc_r;
    logic [XLEN-1:0]        rs1_r;
    logic [XLEN-1:0]        rs2_r;
    logic [XLEN-1:0]        imm_r;
    logic signed [XLEN-1:0] srs1;
    logic signed [XLEN-1:0] srs2;
    logic [XLEN-1:0]        jalr_sum;
    logic                   cond_true;
    br_kind_e               kind_r;
    br_cond_e               cond_r;

    assign srs1     = rs1_r;
    assign srs2     = rs2_r;
    assign jalr_sum = rs1_r + imm_r;

    always_comb begin
        case (cond_r)
            BR_EQ:   cond_true = rs1_r == rs2_r;
            BR_NE:   cond_true = rs1_r != rs2_r;
            BR_LT:   cond_true = srs1 < srs2;
            BR_GE:   cond_true = srs1 >= srs2;
            BR_LTU:  cond_true = rs1_r < rs2_r;
            BR_GEU:  cond_true = rs1_r >= rs2_r;
            default: cond_true = 1'b0;
        endcase
    end

    assign take   = (kind_r == BK_COND) ? cond_true : 1'b1;    // Jumps always taken
    assign target = (kind_r == BK_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : pc_r + imm_r;
    assign link   = pc_r + LINK_OFS;

    always_ff @(posedge clock) begin
        if (reset) begin
            branch_done <= 1'b0;
            pc_r        <= '0;
            rs1_r       <= '0;
            rs2_r       <= '0;
            imm_r       <= '0;
            kind_r      <= BK_COND;
            cond_r      <= BR_EQ;
            out_tag     <= '0;
        end else begin
            branch_done <= branch_en;
            if (branch_en) begin
                pc_r    <= pc;
                rs1_r   <= rs1;
                rs2_r   <= rs2;
                imm_r   <= imm;
                kind_r  <= kind;
                cond_r  <= cond;
                out_tag <= in_tag;
            end
        end
    end

endmodule

//--- verilog/mult_stages.sv
`timescale 1ns/100ps

module mult_stages import isa_pkg::*, exec_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  logic [PROD_W-1:0] mcand,
    input  logic [PROD_W-1:0] mplier,
    input  alu_func_e         func,
    input  logic              start,
    input  logic [TAG_W-1:0]  in_tag,
    output logic [XLEN-1:0]   product,
    output logic              done,
    output logic [TAG_W-1:0]  out_tag
);

    // Stage inputs, fed from the ports or the previous stage
    logic [PROD_W-1:0] in_sum    [MULT_STAGES];
    logic [PROD_W-1:0] in_mcand  [MULT_STAGES];
    logic [PROD_W-1:0] in_mplier [MULT_STAGES];
    logic              in_valid  [MULT_STAGES];
    logic [TAG_W-1:0]  in_tag_s  [MULT_STAGES];
    alu_func_e         in_func   [MULT_STAGES];

    // Stage registers
    logic [PROD_W-1:0] sum_q     [MULT_STAGES];
    logic [PROD_W-1:0] mcand_q   [MULT_STAGES];
    logic [PROD_W-1:0] mplier_q  [MULT_STAGES];
    logic              valid_q   [MULT_STAGES];
    logic [TAG_W-1:0]  tag_q     [MULT_STAGES];
    alu_func_e         func_q    [MULT_STAGES];

    always_comb begin
        in_sum[0]    = '0;
        in_mcand[0]  = mcand;
        in_mplier[0] = mplier;
        in_valid[0]  = start;
        in_tag_s[0]  = in_tag;
        in_func[0]   = func;
        for (int i = 1; i < MULT_STAGES; i++) begin
            in_sum[i]    = sum_q[i-1];
            in_mcand[i]  = mcand_q[i-1];
            in_mplier[i] = mplier_q[i-1];
            in_valid[i]  = valid_q[i-1];
            in_tag_s[i]  = tag_q[i-1];
            in_func[i]   = func_q[i-1];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < MULT_STAGES; i++) begin
                valid_q[i]  <= 1'b0;
                sum_q[i]    <= '0;
                mcand_q[i]  <= '0;
                mplier_q[i] <= '0;
                tag_q[i]    <= '0;
                func_q[i]   <= ALU_MUL;
            end
        end else begin
            for (int i = 0; i < MULT_STAGES; i++) begin
                valid_q[i]  <= in_valid[i];
                sum_q[i]    <= in_sum[i]
                             + in_mcand[i] * PROD_W'(in_mplier[i][SLICE_W-1:0]);
                mcand_q[i]  <= in_mcand[i] << SLICE_W;     // Next slice weight
                mplier_q[i] <= in_mplier[i] >> SLICE_W;
                tag_q[i]    <= in_tag_s[i];
                func_q[i]   <= in_func[i];
            end
        end
    end

    // Low word for MUL, high word for the MULH variants
    assign product = (func_q[MULT_STAGES-1] == ALU_MUL) ? sum_q[MULT_STAGES-1][XLEN-1:0]
                                                        : sum_q[MULT_STAGES-1][PROD_W-1:XLEN];
    assign done    = valid_q[MULT_STAGES-1];
    assign out_tag = tag_q[MULT_STAGES-1];

endmodule

//--- verilog/mult_unit.sv
`timescale 1ns/100ps

module mult_unit import isa_pkg::*, exec_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  logic [XLEN-1:0]  mcand,
    input  logic [XLEN-1:0]  mplier,
    input  alu_func_e        func,
    input  logic             mult_en,
    input  logic [TAG_W-1:0] in_tag,
    output logic [XLEN-1:0]  product,
    output logic             mult_done,
    output logic [TAG_W-1:0] out_tag
);

    logic [XLEN-1:0]   mcand_r;
    logic [XLEN-1:0]   mplier_r;
    logic [TAG_W-1:0]  tag_r;
    logic              start_r;
    logic              mcand_signed;
    logic              mplier_signed;
    logic [PROD_W-1:0] mcand_ext;
    logic [PROD_W-1:0] mplier_ext;
    alu_func_e         func_r;

    always_comb begin
        case (func_r)
            ALU_MUL, ALU_MULH: begin
                mcand_signed  = 1'b1;
                mplier_signed = 1'b1;
            end
            ALU_MULHSU: begin
                mcand_signed  = 1'b1;    // rs1 signed, rs2 unsigned
                mplier_signed = 1'b0;
            end
            default: begin
                mcand_signed  = 1'b0;
                mplier_signed = 1'b0;
            end
        endcase
    end

    assign mcand_ext  = {{XLEN{mcand_signed & mcand_r[XLEN-1]}}, mcand_r};
    assign mplier_ext = {{XLEN{mplier_signed & mplier_r[XLEN-1]}}, mplier_r};

    mult_stages u_stages (
        .clock   (clock),
        .reset   (reset),
        .mcand   (mcand_ext),
        .mplier  (mplier_ext),
        .func    (func_r),
        .start   (start_r),
        .in_tag  (tag_r),
        .product (product),
        .done    (mult_done),
        .out_tag (out_tag)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            start_r  <= 1'b0;
            mcand_r  <= '0;
            mplier_r <= '0;
            func_r   <= ALU_MUL;
            tag_r    <= '0;
        end else begin
            start_r <= mult_en;
            if (mult_en) begin
                mcand_r  <= mcand;
                mplier_r <= mplier;
                func_r   <= func;
                tag_r    <= in_tag;
            end
        end
    end

endmodule

//--- verilog/ex_stage.sv
`timescale 1ns/100ps

module ex_stage import isa_pkg::*, exec_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  logic [XLEN-1:0]  opa,
    input  logic [XLEN-1:0]  opb,
    input  alu_func_e        alu_func,
    input  logic [TAG_W-1:0] alu_in_tag,
    input  logic             alu_en,
    input  logic [XLEN-1:0]  pc,
    input  logic [XLEN-1:0]  rs1,
    input  logic [XLEN-1:0]  rs2,
    input  logic [XLEN-1:0]  imm,
    input  br_kind_e         br_kind,
    input  br_cond_e         br_cond,
    input  logic [TAG_W-1:0] br_in_tag,
    input  logic             branch_en,
    input  logic [XLEN-1:0]  mcand,
    input  logic [XLEN-1:0]  mplier,
    input  alu_func_e        mult_func,
    input  logic [TAG_W-1:0] mult_in_tag,
    input  logic             mult_en,
    output logic [XLEN-1:0]  alu_result,
    output logic [TAG_W-1:0] alu_tag,
    output logic             alu_done,
    output logic             br_take,
    output logic [XLEN-1:0]  br_target,
    output logic [XLEN-1:0]  br_link,
    output logic [TAG_W-1:0] br_tag,
    output logic             br_done,
    output logic [XLEN-1:0]  mult_product,
    output logic [TAG_W-1:0] mult_tag,
    output logic             mult_done
);

    alu u_alu (
        .clock    (clock),
        .reset    (reset),
        .opa      (opa),
        .opb      (opb),
        .func     (alu_func),
        .alu_en   (alu_en),
        .in_tag   (alu_in_tag),
        .result   (alu_result),
        .alu_done (alu_done),
        .out_tag  (alu_tag)
    );

    branch_unit u_branch (
        .clock       (clock),
        .reset       (reset),
        .pc          (pc),
        .rs1         (rs1),
        .rs2         (rs2),
        .imm         (imm),
        .kind        (br_kind),
        .cond        (br_cond),
        .branch_en   (branch_en),
        .in_tag      (br_in_tag),
        .take        (br_take),
        .target      (br_target),
        .link        (br_link),
        .branch_done (br_done),
        .out_tag     (br_tag)
    );

    mult_unit u_mult (
        .clock     (clock),
        .reset     (reset),
        .mcand     (mcand),
        .mplier    (mplier),
        .func      (mult_func),
        .mult_en   (mult_en),
        .in_tag    (mult_in_tag),
        .product   (mult_product),
        .mult_done (mult_done),
        .out_tag   (mult_tag)
    );

endmodule

//--- tb/ex_stage_tb.sv
`timescale 1ns/100ps

module ex_stage_tb import isa_pkg::*, exec_pkg::*; ();

    typedef struct packed {
        logic [7:0]       unit;
        logic             with_prev;
        logic [3:0]       func;
        logic [2:0]       cond;
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  b;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  imm;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  res;
        logic             take;
        logic [XLEN-1:0]  tgt;
    } test_t;

    typedef struct packed {
        int               cyc;    // Issue cycle
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  res;
        logic             take;
        logic [XLEN-1:0]  tgt;
    } exp_t;

    logic clock;
    logic reset;
    logic [XLEN-1:0] opa, opb, pc, rs1, rs2, imm, mcand, mplier;
    logic [XLEN-1:0] alu_result, br_target, br_link, mult_product;
    logic [TAG_W-1:0] alu_in_tag, br_in_tag, mult_in_tag, alu_tag, br_tag, mult_tag;
    logic alu_en, branch_en, mult_en, alu_done, br_take, br_done, mult_done;
    alu_func_e alu_func;
    alu_func_e mult_func;
    br_kind_e br_kind;
    br_cond_e br_cond;

    test_t tests[$];
    exp_t  alu_q[$];
    exp_t  br_q[$];
    exp_t  mult_q[$];
    int    cycle = 0;
    int    limit = 0;
    int    value_errs = 0;
    int    proto_errs = 0;
    int    end_errs = 0;
    logic  started;

    ex_stage u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (limit != 0 && cycle >= limit) begin
            $display("Timeout after %0d cycles, results never arrived", cycle);
            $display("Errors: %0d value, %0d protocol, %0d end of run",
                     value_errs, proto_errs, end_errs);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] want);
        assert (got === want) else begin
            $display("ERR %s expected %h got %h at cycle %0d", name, want, got, cycle);
            value_errs++;
        end
    endtask

    task automatic check_latency(input string name, input int issued, input int want_lat);
        assert (cycle - issued == want_lat) else begin
            $display("%s came %0d cycles after issue instead of %0d",
                     name, cycle - issued, want_lat);
            proto_errs++;
        end
    endtask

    // Outputs are sampled on the falling edge
    always @(negedge clock) begin
        exp_t e;
        if (!reset && !started) begin
            assert (!alu_done && !br_done && !mult_done) else begin
                $display("A done output was high at cycle %0d before any issue", cycle);
                proto_errs++;
            end
        end
        if (alu_done) begin
            assert (alu_q.size() != 0) else begin
                $display("alu_done pulsed with no ALU operation outstanding");
                proto_errs++;
            end
            if (alu_q.size() != 0) begin
                e = alu_q.pop_front();
                check_latency("alu_done", e.cyc, 1);
                check_value("alu_result", alu_result, e.res);
                check_value("alu_tag", 32'(alu_tag), 32'(e.tag));
            end
        end
        if (br_done) begin
            assert (br_q.size() != 0) else begin
                $display("br_done pulsed with no branch outstanding");
                proto_errs++;
            end
            if (br_q.size() != 0) begin
                e = br_q.pop_front();
                check_latency("br_done", e.cyc, 1);
                check_value("br_take", 32'(br_take), 32'(e.take));
                check_value("br_target", br_target, e.tgt);
                check_value("br_link", br_link, e.res);    // Link is the result column
                check_value("br_tag", 32'(br_tag), 32'(e.tag));
            end
        end
        if (mult_done) begin
            assert (mult_q.size() != 0) else begin
                $display("mult_done pulsed with no multiply outstanding");
                proto_errs++;
            end
            if (mult_q.size() != 0) begin
                e = mult_q.pop_front();
                check_latency("mult_done", e.cyc, MULT_LATENCY);
                check_value("mult_product", mult_product, e.res);
                check_value("mult_tag", 32'(mult_tag), 32'(e.tag));
            end
        end
    end

    task automatic load_tests(input int fd);
        string       line;
        int          cnt;
        logic [7:0]  unit_c;
        logic [31:0] w, fn, cd, tg, tk;
        logic [31:0] va, vb, vpc, vimm, vres, vtgt;
        test_t       t;
        while (!$feof(fd)) begin
            cnt = $fgets(line, fd);
            if (cnt > 0 && line[0] != "#") begin
                cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h",
                              unit_c, w, fn, cd, va, vb, vpc, vimm, tg, vres, tk, vtgt);
                if (cnt == 12) begin
                    t.unit      = unit_c;
                    t.with_prev = w[0];
                    t.func      = fn[3:0];
                    t.cond      = cd[2:0];
                    t.a         = va;
                    t.b         = vb;
                    t.pc        = vpc;
                    t.imm       = vimm;
                    t.tag       = tg[TAG_W-1:0];
                    t.res       = vres;
                    t.take      = tk[0];
                    t.tgt       = vtgt;
                    tests.push_back(t);
                end
            end
        end
    endtask

    task automatic clear_enables();
        alu_en    = 1'b0;
        branch_en = 1'b0;
        mult_en   = 1'b0;
    endtask

    task automatic issue(input test_t t);
        exp_t e;
        e.cyc  = cycle;
        e.tag  = t.tag;
        e.res  = t.res;
        e.take = t.take;
        e.tgt  = t.tgt;
        case (t.unit)
            "A": begin
                opa        = t.a;
                opb        = t.b;
                alu_func   = alu_func_e'(t.func);
                alu_in_tag = t.tag;
                alu_en     = 1'b1;
                alu_q.push_back(e);
            end
            "B": begin
                rs1       = t.a;
                rs2       = t.b;
                pc        = t.pc;
                imm       = t.imm;
                br_kind   = br_kind_e'(t.func[1:0]);
                br_cond   = br_cond_e'(t.cond);
                br_in_tag = t.tag;
                branch_en = 1'b1;
                br_q.push_back(e);
            end
            "M": begin
                mcand       = t.a;
                mplier      = t.b;
                mult_func   = alu_func_e'(t.func);
                mult_in_tag = t.tag;
                mult_en     = 1'b1;
                mult_q.push_back(e);
            end
            default: begin
                $display("Test line with unknown unit letter skipped");
                end_errs++;
            end
        endcase
    endtask

    task automatic run_tests();
        int i;
        int drain;
        repeat (4) @(posedge clock);
        #1 reset = 1'b0;
        repeat (3) @(posedge clock);    // Idle, all dones must stay low
        i = 0;
        while (i < tests.size()) begin
            @(posedge clock);
            #1;
            clear_enables();
            started = 1'b1;
            issue(tests[i]);
            i++;
            while (i < tests.size() && tests[i].with_prev) begin
                issue(tests[i]);
                i++;
            end
        end
        @(posedge clock);
        #1;
        clear_enables();
        drain = 0;
        while (alu_q.size() + br_q.size() + mult_q.size() != 0
               && drain < MULT_LATENCY + 2) begin
            @(posedge clock);
            drain++;
        end
        assert (alu_q.size() == 0 && br_q.size() == 0 && mult_q.size() == 0) else begin
            $display("Results still outstanding at the end of the run");
            end_errs++;
        end
        repeat (MULT_LATENCY + 2) @(posedge clock);    // Window for stray done pulses
    endtask

    initial begin
        int fd;
        reset       = 1'b1;
        started     = 1'b0;
        opa         = '0;
        opb         = '0;
        alu_func    = ALU_ADD;
        alu_in_tag  = '0;
        pc          = '0;
        rs1         = '0;
        rs2         = '0;
        imm         = '0;
        br_kind     = BK_COND;
        br_cond     = BR_EQ;
        br_in_tag   = '0;
        mcand       = '0;
        mplier      = '0;
        mult_func   = ALU_MUL;
        mult_in_tag = '0;
        clear_enables();
        fd = $fopen("tb/ex_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open tb/ex_tests.txt");
            $display("Test failed");
            $finish;
        end else begin
            load_tests(fd);
            $fclose(fd);
            limit = tests.size() + MULT_LATENCY + 20;
            run_tests();
            $display("Errors: %0d value, %0d protocol, %0d end of run",
                     value_errs, proto_errs, end_errs);
            if (value_errs == 0 && proto_errs == 0 && end_errs == 0 && tests.size() != 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

//--- tb/ex_tests.txt
# unit with_prev func/kind cond a(opa/rs1/mcand) b(opb/rs2/mplier) pc imm tag result take target
# with_prev 1 issues in the same cycle as the line above, result is the link for branches
A 0 0 0 00000005 00000003 00000000 00000000 01 00000008 0 00000000
A 0 0 0 7fffffff 00000001 00000000 00000000 02 80000000 0 00000000
A 0 1 0 00000003 00000005 00000000 00000000 03 fffffffe 0 00000000
A 0 2 0 f0f0ff00 0ff0f0f0 00000000 00000000 04 00f0f000 0 00000000
A 0 3 0 f0f00000 0000abcd 00000000 00000000 05 f0f0abcd 0 00000000
A 0 4 0 ffff0000 0f0f0f0f 00000000 00000000 06 f0f00f0f 0 00000000
A 0 5 0 ffffffff 00000001 00000000 00000000 07 00000001 0 00000000
A 0 6 0 ffffffff 00000001 00000000 00000000 08 00000000 0 00000000
B 0 0 0 00000005 00000005 00001000 00000010 10 00001004 1 00001010
B 0 0 1 00000005 00000005 00002000 fffffff0 11 00002004 0 00001ff0
B 0 0 4 ffffffff 00000001 00003000 00000100 12 00003004 1 00003100
B 0 0 6 ffffffff 00000001 00003000 00000100 13 00003004 0 00003100
B 0 0 5 80000000 7fffffff 00004000 00000008 14 00004004 0 00004008
B 0 0 7 80000000 7fffffff 00004000 00000008 15 00004004 1 00004008
M 0 a 0 00000003 00000007 00000000 00000000 20 00000015 0 00000000
M 0 a 0 80000000 ffffffff 00000000 00000000 21 80000000 0 00000000
A 1 5 0 00000001 80000000 00000000 00000000 09 00000000 0 00000000
B 1 0 5 00000007 00000007 00005000 00000020 16 00005004 1 00005020
M 0 b 0 80000000 ffffffff 00000000 00000000 22 00000000 0 00000000
A 1 6 0 00000001 80000000 00000000 00000000 0a 00000001 0 00000000
B 1 0 6 00000001 80000000 00006000 fffff000 17 00006004 1 00005000
M 0 b 0 80000000 80000000 00000000 00000000 23 40000000 0 00000000
A 1 7 0 00000001 ffffffe4 00000000 00000000 0b 00000010 0 00000000
B 1 1 1 00000000 00000000 00007000 00000800 18 00007004 1 00007800
M 0 d 0 ffffffff ffffffff 00000000 00000000 24 fffffffe 0 00000000
A 1 8 0 80000000 00000021 00000000 00000000 0c 40000000 0 00000000
B 1 2 0 00008001 00000000 00009000 00000002 19 00009004 1 00008002
M 0 c 0 ffffffff ffffffff 00000000 00000000 25 ffffffff 0 00000000
A 1 9 0 80000000 0000001f 00000000 00000000 0d ffffffff 0 00000000
B 1 2 0 00008000 00000000 0000a000 00000005 1a 0000a004 1 00008004
M 0 c 0 80000000 80000000 00000000 00000000 26 c0000000 0 00000000
A 1 9 0 f0000000 00000104 00000000 00000000 0e ff000000 0 00000000
M 0 d 0 80000000 80000000 00000000 00000000 27 40000000 0 00000000
A 1 8 0 f0000000 00000004 00000000 00000000 0f 0f000000 0 00000000
M 0 b 0 ffffffff ffffffff 00000000 00000000 28 00000000 0 00000000
M 0 a 0 12345678 00000010 00000000 00000000 29 23456780 0 00000000
M 0 d 0 12345678 00000010 00000000 00000000 2a 00000001 0 00000000
M 0 b 0 ffffffff 00000002 00000000 00000000 2b ffffffff 0 00000000

//--- vlog.f
verilog/isa_pkg.sv
verilog/exec_pkg.sv
verilog/alu.sv
verilog/branch_unit.sv
verilog/mult_stages.sv
verilog/mult_unit.sv
verilog/ex_stage.sv
tb/ex_stage_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --assert --timescale 1ns/100ps --top-module ex_stage_tb \
    -f vlog.f -o sim > build.log 2>&1 \
    && ./obj_dir/sim > sim.log 2>&1 \
    || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "^Test completed successfully$" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL, see sim.log"; exit 1; }
